// File: tb.f
hdl/cr16_pkg.sv
hdl/alu.sv
hdl/regfile.sv
hdl/control_and_decoder.sv
hdl/datapath.sv
hdl/cr16_cpu.sv
dv/tb_clock_gen.sv
dv/cr16_asserts.sv
dv/tb_cr16.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cr16 testbench with verilator, pass only if the log shows the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_cr16 -f tb.f --Mdir "$OBJ" -o sim_cr16
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

"./$OBJ/sim_cr16" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: dv/tb_cr16.sv
// testbench for the cr16 core that runs small programs to halt and checks the data area against a model
`timescale 1ns/1ns
`default_nettype none

module tb_cr16;
    import cr16_pkg::*;

    logic        clk;
    logic        reset;
    logic        reset_req;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;
    logic [15:0] mem_rdata;
    logic        mem_we;
    logic        halted;

    logic [15:0] mem     [256];     // dut memory decoded on the low 8 address bits
    logic [15:0] ref_mem [256];     // model copy
    logic [15:0] prog [$];
    int          errors     = 0;
    int          tests_run  = 0;
    int          tests_bad  = 0;
    bit          timed_out  = 0;
    int          asrt_fails;

    tb_clock_gen u_clk (.reset_req(reset_req), .clk(clk), .reset(reset));

    cr16_cpu #(.reset_pc(16'h0000)) u_dut (
        .clk(clk), .reset(reset), .mem_rdata(mem_rdata), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_we(mem_we), .halted(halted)
    );

    assign mem_rdata = mem[mem_addr[7:0]];  // same-cycle read

    always @(posedge clk) begin
        if (mem_we) mem[mem_addr[7:0]] <= mem_wdata;
    end

    // instruction encoders
    function automatic logic [15:0] rop(alu_op_t op, int rd, int rs);
        return {CLS_RTYPE, 4'(rd), op, 4'(rs)};
    endfunction

    function automatic logic [15:0] imm(instr_class_t cls, int rd, int val);
        return {cls, 4'(rd), 8'(val)};
    endfunction

    function automatic logic [15:0] mop(instr_class_t cls, int rd, int rs);
        return {cls, 4'(rd), 4'd0, 4'(rs)};
    endfunction

    // r15 holds the address and 0x80+slot sign-extends into the data area
    task automatic store_to_slot(int rd, int slot);
        prog.push_back(imm(CLS_MOVI, 15, 8'h80 + slot));
        prog.push_back(mop(CLS_STOR, rd, 15));
    endtask

    task automatic op_to_slot(alu_op_t op, int ra, int rb, int slot);
        prog.push_back(rop(MOV, 6, ra));    // work on r6 so the sources survive
        prog.push_back(rop(op, 6, rb));
        store_to_slot(6, slot);
    endtask

    task automatic load_memories();
        logic [7:0] x;
        for (int i = 0; i < 256; i++) begin
            x = 8'(i);
            mem[i] = {x ^ 8'ha5, ~x};       // filler differs at every address
        end
        foreach (prog[i]) mem[i] = prog[i];
        mem[prog.size()] = {CLS_HALT, 12'h000};
        for (int i = 0; i < 256; i++) ref_mem[i] = mem[i];
    endtask

    // instruction-level reference model over ref_mem
    task automatic run_model();
        logic [15:0] r [16];
        logic [15:0] pc;
        logic [15:0] ins;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] sx;
        logic [16:0] wide;
        logic        c;
        logic        z;
        logic        l;
        logic        done;
        int          sh;
        int          steps;
        for (int i = 0; i < 16; i++) r[i] = '0;
        pc    = '0;
        c     = 0;
        z     = 0;
        l     = 0;
        done  = 0;
        steps = 0;
        while (!done && steps < 1000) begin
            ins = ref_mem[pc[7:0]];
            pc  = pc + 1;
            steps++;
            a  = r[ins[11:8]];
            b  = r[ins[3:0]];
            sx = {{8{ins[7]}}, ins[7:0]};
            case (instr_class_t'(ins[15:12]))
                CLS_RTYPE: begin
                    sh = b[4] ? int'(b[4:0]) - 32 : int'(b[4:0]);  // -16 .. 15
                    case (alu_op_t'(ins[7:4]))
                        AND:  r[ins[11:8]] = a & b;
                        OR:   r[ins[11:8]] = a | b;
                        XOR:  r[ins[11:8]] = a ^ b;
                        NOT:  r[ins[11:8]] = ~b;
                        MOV:  r[ins[11:8]] = b;
                        LSH:  r[ins[11:8]] = (sh >= 0) ? a << sh : a >> (-sh);
                        ASHU: r[ins[11:8]] = (sh >= 0) ? a << sh
                                            : $unsigned($signed(a) >>> (-sh));
                        ADD, ADDU, ADDC: begin
                            wide = {1'b0, a} + {1'b0, b};
                            if (ins[7:4] == ADDC) wide = wide + c;
                            r[ins[11:8]] = wide[15:0];
                            if (ins[7:4] != ADDU) c = wide[16];     // addu keeps c
                        end
                        SUB, SUBC: begin
                            wide = {1'b0, a} - {1'b0, b};
                            if (ins[7:4] == SUBC) wide = wide - c;
                            r[ins[11:8]] = wide[15:0];
                            c = wide[16];       // borrow
                        end
                        CMP: begin
                            z = (a == b);
                            l = (a < b);
                        end
                        default: ;              // nop
                    endcase
                end
                CLS_ADDI: begin
                    wide = {1'b0, a} + {1'b0, sx};
                    r[ins[11:8]] = wide[15:0];
                    c = wide[16];
                end
                CLS_MOVI:  r[ins[11:8]] = sx;
                CLS_LOAD:  r[ins[11:8]] = ref_mem[b[7:0]];
                CLS_STOR:  ref_mem[b[7:0]] = a;
                CLS_SCOND: case (ins[7:4])
                    4'd0:    r[ins[11:8]] = 16'(z);
                    4'd1:    r[ins[11:8]] = 16'(!z);
                    4'd2:    r[ins[11:8]] = 16'(l);
                    4'd3:    r[ins[11:8]] = 16'(!l);
                    default: r[ins[11:8]] = '0;
                endcase
                CLS_HALT:  done = 1;
                default:   ;
            endcase
        end
    endtask

    task automatic run_test(input string name);
        int limit;
        int cnt;
        int mism;
        limit = 4 * (prog.size() + 1) + 50;
        mism  = 0;
        cnt   = 0;
        @(posedge clk) reset_req <= 1'b1;
        @(posedge clk) reset_req <= 1'b0;
        wait (reset == 1'b0);
        load_memories();
        while (reset !== 1'b1 || halted !== 1'b1) begin
            @(posedge clk);
            cnt++;
            if (cnt > limit + 12) begin     // 12 covers the reset window
                $display("timeout in test %s, no halt after %0d cycles", name, cnt);
                timed_out = 1;
                break;
            end
        end
        if (!timed_out) begin
            run_model();
            for (int i = 128; i < 256; i++) begin
                assert (mem[i] === ref_mem[i])
                else begin
                    $display("** Error at %0t: mem[%0d] expected %h, got %h",
                             $time, i, ref_mem[i], mem[i]);
                    mism++;
                end
            end
            errors += mism;
            tests_run++;
            if (mism != 0) tests_bad++;
            $display("test %-16s %s (%0d mismatches, %0d cycles)", name,
                     (mism == 0) ? "ok" : "FAILED", mism, cnt);
        end
        prog.delete();
    endtask

    initial begin
        reset_req = 1'b0;
        void'($urandom(32'h24fb));
        load_memories();        // filler and a halt so mem_rdata is known from time zero

        // logic and shifts
        prog.push_back(imm(CLS_MOVI, 1, 8'h5a));
        prog.push_back(imm(CLS_MOVI, 2, 8'hc3));   // ffc3
        prog.push_back(imm(CLS_MOVI, 3, 3));
        prog.push_back(imm(CLS_MOVI, 4, -3));
        prog.push_back(imm(CLS_MOVI, 5, -16));
        for (int i = 1; i <= 5; i++) store_to_slot(i, i - 1);
        op_to_slot(AND, 1, 2, 5);
        op_to_slot(OR, 1, 2, 6);
        op_to_slot(XOR, 1, 2, 7);
        op_to_slot(NOT, 1, 2, 8);
        op_to_slot(MOV, 1, 2, 9);
        op_to_slot(LSH, 1, 3, 10);
        op_to_slot(LSH, 2, 4, 11);
        op_to_slot(ASHU, 2, 3, 12);
        op_to_slot(ASHU, 2, 4, 13);
        op_to_slot(LSH, 2, 5, 14);
        op_to_slot(ASHU, 2, 5, 15);
        run_test("logic_shift");

        // arithmetic and carry chains
        if (!timed_out) begin
            prog.push_back(imm(CLS_MOVI, 1, 100));
            prog.push_back(imm(CLS_MOVI, 2, -1));
            op_to_slot(ADD, 1, 2, 0);
            op_to_slot(ADDU, 1, 2, 1);
            op_to_slot(SUB, 1, 2, 2);
            prog.push_back(imm(CLS_MOVI, 7, 5));
            prog.push_back(imm(CLS_ADDI, 7, -7));
            store_to_slot(7, 3);
            prog.push_back(rop(MOV, 8, 2));         // first operand is 0001_ffff
            prog.push_back(imm(CLS_MOVI, 9, 1));
            prog.push_back(imm(CLS_MOVI, 10, 1));   // second operand is 0002_0001
            prog.push_back(imm(CLS_MOVI, 11, 2));
            prog.push_back(rop(ADD, 8, 10));
            prog.push_back(rop(MOV, 13, 1));
            prog.push_back(rop(ADDU, 13, 1));       // c must survive this
            prog.push_back(rop(ADDC, 9, 11));
            store_to_slot(8, 4);
            store_to_slot(9, 5);
            store_to_slot(13, 6);
            prog.push_back(imm(CLS_MOVI, 8, 0));
            prog.push_back(imm(CLS_MOVI, 9, 5));
            prog.push_back(rop(SUB, 8, 10));
            prog.push_back(rop(SUBC, 9, 11));
            store_to_slot(8, 7);
            store_to_slot(9, 8);
            run_test("arith_carry");
        end

        // compare then all four conditions
        if (!timed_out) begin
            for (int p = 0; p < 3; p++) begin
                prog.push_back(imm(CLS_MOVI, 1, (p == 2) ? 9 : ((p == 1) ? 3 : 5)));
                prog.push_back(imm(CLS_MOVI, 2, (p == 2) ? 3 : ((p == 1) ? 9 : 5)));
                prog.push_back(rop(CMP, 1, 2));
                for (int c = 0; c < 4; c++) begin
                    prog.push_back({CLS_SCOND, 4'(3 + c), 4'(c), 4'd0});
                end
                for (int c = 0; c < 4; c++) store_to_slot(3 + c, 4 * p + c);
            end
            run_test("cmp_scond");
        end

        // loads, stores and nops
        if (!timed_out) begin
            prog.push_back(imm(CLS_MOVI, 1, 8'h2b));
            prog.push_back(imm(CLS_MOVI, 2, -100));
            store_to_slot(1, 0);
            store_to_slot(2, 1);
            prog.push_back(rop(NOP, 1, 2));
            prog.push_back(imm(CLS_MOVI, 15, 8'h80));
            prog.push_back(mop(CLS_LOAD, 3, 15));
            prog.push_back(rop(NOP, 3, 1));
            prog.push_back(imm(CLS_MOVI, 15, 8'h81));
            prog.push_back(mop(CLS_LOAD, 4, 15));
            prog.push_back(rop(NOP, 4, 1));
            store_to_slot(3, 2);
            store_to_slot(4, 3);
            store_to_slot(1, 4);
            store_to_slot(2, 5);
            run_test("load_store_nop");
        end

        // random register ops and immediates
        if (!timed_out) begin
            for (int i = 0; i < 40; i++) begin
                case ($urandom % 3)
                    0: prog.push_back(imm(CLS_ADDI, $urandom % 16, $urandom));
                    1: prog.push_back(imm(CLS_MOVI, $urandom % 16, $urandom));
                    default: prog.push_back(rop(alu_op_t'($urandom % 14),
                                                $urandom % 16, $urandom % 16));
                endcase
            end
            for (int i = 0; i < 15; i++) store_to_slot(i, i);
            prog.push_back(imm(CLS_MOVI, 14, 8'h8f));
            prog.push_back(mop(CLS_STOR, 15, 14));
            run_test("random_ops");
        end

        asrt_fails = u_dut.u_ctrl.u_asserts.fail_count;
        $display("tests %0d, failed %0d, data errors %0d, assertion failures %0d",
                 tests_run, tests_bad, errors, asrt_fails);
        if (timed_out || errors != 0 || asrt_fails != 0) begin
            $display("Finished with errors");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/cr16_asserts.sv
// concurrent checks on fsm sequencing and memory strobes for binding into the cr16 controller
`timescale 1ns/1ns
`default_nettype none

module cr16_asserts (
    input logic                 clk,
    input logic                 reset,
    input cr16_pkg::cpu_state_t state,
    input logic                 mem_we,
    input logic                 halted
);
    import cr16_pkg::*;

    int fail_count = 0;     // read by the testbench at the end of the run

    // write strobe only in store and only one cycle wide
    a_we_in_store: assert property (@(posedge clk) disable iff (!reset)
        mem_we |-> state == S_STORE)
    else begin
        fail_count++;
        $error("mem_we high outside S_STORE");
    end

    a_we_one_cycle: assert property (@(posedge clk) disable iff (!reset)
        mem_we |=> !mem_we)
    else begin
        fail_count++;
        $error("mem_we held for more than one cycle");
    end

    a_fetch_decode: assert property (@(posedge clk) disable iff (!reset)
        state == S_FETCH |=> state == S_DECODE)
    else begin
        fail_count++;
        $error("S_DECODE did not follow S_FETCH");
    end

    a_exec_store_ret: assert property (@(posedge clk) disable iff (!reset)
        (state == S_EXEC || state == S_STORE) |=> state == S_FETCH)
    else begin
        fail_count++;
        $error("exec or store did not return to fetch");
    end

    a_load_seq: assert property (@(posedge clk) disable iff (!reset)
        state == S_LOAD_ADDR |=> state == S_LOAD_WB)
    else begin
        fail_count++;
        $error("S_LOAD_WB did not follow S_LOAD_ADDR");
    end

    a_halt_sticky: assert property (@(posedge clk) disable iff (!reset)
        halted |=> halted)
    else begin
        fail_count++;
        $error("halted dropped without reset");
    end

    // first sampled cycle out of reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(reset) |-> (!mem_we && !halted))
    else begin
        fail_count++;
        $error("strobes active right after reset");
    end

endmodule

bind control_and_decoder cr16_asserts u_asserts (
    .clk    (clk),
    .reset  (reset),
    .state  (state),
    .mem_we (mem_we),
    .halted (halted)
);

`default_nettype wire

// File: dv/tb_clock_gen.sv
// testbench clock and reset source, 20 ns clock and an 8-cycle active-low reset on each request
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    input  logic reset_req,     // one-cycle request for a fresh reset
    output logic clk,
    output logic reset          // active low
);
    int unsigned hold;          // cycles of reset still to go

    initial begin
        clk   = 1'b0;
        reset = 1'b0;           // held from time zero
        hold  = 8;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset_req) begin
            reset <= 1'b0;
            hold  <= 8;
        end else if (hold > 0) begin
            hold  <= hold - 1;
            reset <= (hold == 1);   // released after the eighth cycle
        end
    end

endmodule

`default_nettype wire

// File: hdl/cr16_cpu.sv
// cr16 core top, joins the control fsm to the datapath and exposes the single-word memory port
`timescale 1ns/1ns
`default_nettype none

module cr16_cpu #(
    parameter logic [cr16_pkg::data_width-1:0] reset_pc = '0
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cr16_pkg::data_width-1:0] mem_rdata,  // combinational read data
    output logic [cr16_pkg::data_width-1:0] mem_addr,
    output logic [cr16_pkg::data_width-1:0] mem_wdata,
    output logic                            mem_we,     // one-cycle write strobe
    output logic                            halted
);
    import cr16_pkg::*;

    logic         ir_load;
    logic         pc_inc;
    logic         reg_we;
    logic         flags_we;
    logic         mdr_load;
    logic         use_imm;
    logic         addr_sel;
    logic [1:0]   wb_sel;
    alu_op_t      alu_op;
    instr_class_t instr_class;
    alu_op_t      op_field;

    control_and_decoder u_ctrl (
        .clk(clk), .reset(reset),
        .instr_class(instr_class), .op_field(op_field),
        .ir_load(ir_load), .pc_inc(pc_inc), .reg_we(reg_we), .flags_we(flags_we),
        .mdr_load(mdr_load), .use_imm(use_imm), .addr_sel(addr_sel), .wb_sel(wb_sel),
        .alu_op(alu_op), .mem_we(mem_we), .halted(halted)
    );

    datapath #(.reset_pc(reset_pc)) u_dp (
        .clk(clk), .reset(reset),
        .ir_load(ir_load), .pc_inc(pc_inc), .reg_we(reg_we), .flags_we(flags_we),
        .mdr_load(mdr_load), .use_imm(use_imm), .addr_sel(addr_sel), .wb_sel(wb_sel),
        .alu_op(alu_op), .mem_rdata(mem_rdata),
        .instr_class(instr_class), .op_field(op_field),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

endmodule

`default_nettype wire

// File: hdl/datapath.sv
// cr16 datapath, holds pc, ir, mdr and flags and routes operands around the alu and register file
`timescale 1ns/1ns
`default_nettype none

module datapath #(
    parameter logic [cr16_pkg::data_width-1:0] reset_pc = '0   // first fetch address
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ir_load,
    input  logic                            pc_inc,
    input  logic                            reg_we,
    input  logic                            flags_we,
    input  logic                            mdr_load,
    input  logic                            use_imm,
    input  logic                            addr_sel,
    input  logic [1:0]                      wb_sel,
    input  cr16_pkg::alu_op_t               alu_op,
    input  logic [cr16_pkg::data_width-1:0] mem_rdata,
    output cr16_pkg::instr_class_t          instr_class,
    output cr16_pkg::alu_op_t               op_field,
    output logic [cr16_pkg::data_width-1:0] mem_addr,
    output logic [cr16_pkg::data_width-1:0] mem_wdata
);
    import cr16_pkg::*;

    logic [data_width-1:0] pc;
    logic [data_width-1:0] ir;
    logic [data_width-1:0] mdr;         // load data
    logic                  c_flag;
    logic                  z_flag;
    logic                  l_flag;
    logic [data_width-1:0] rdata_a;     // rdest
    logic [data_width-1:0] rdata_b;     // rsrc
    logic [data_width-1:0] imm_ext;
    logic [data_width-1:0] alu_b;
    logic [data_width-1:0] alu_result;
    logic [data_width-1:0] wb_data;
    logic                  alu_carry;
    logic                  alu_zero;
    logic                  alu_lower;
    logic                  cond_true;
    cond_t                 cond;

    // instruction fields
    assign instr_class = instr_class_t'(ir[15:12]);
    assign op_field    = alu_op_t'(ir[7:4]);
    assign cond        = cond_t'(ir[7:4]);            // scond shares the op field
    assign imm_ext     = {{8{ir[7]}}, ir[7:0]};

    assign alu_b     = use_imm ? imm_ext : rdata_b;
    assign mem_addr  = (addr_sel == ADDR_REG) ? rdata_b : pc;
    assign mem_wdata = rdata_a;                       // stor writes rdest

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= reset_pc;
        end else if (pc_inc) begin
            pc <= pc + 1'b1;    // word addressed
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load)  ir  <= mem_rdata;
        if (mdr_load) mdr <= mem_rdata;
    end

    // cmp owns z and l, the add/sub family owns c
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            c_flag <= 1'b0;
            z_flag <= 1'b0;
            l_flag <= 1'b0;
        end else if (flags_we) begin
            if (alu_op == CMP) begin
                z_flag <= alu_zero;
                l_flag <= alu_lower;
            end else begin
                c_flag <= alu_carry;
            end
        end
    end

    always_comb begin
        case (cond)
            COND_EQ: cond_true = z_flag;
            COND_NE: cond_true = !z_flag;
            COND_LO: cond_true = l_flag;
            COND_HS: cond_true = !l_flag;
            default: cond_true = 1'b0;      // undefined conditions never hold
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_MDR:  wb_data = mdr;
            WB_COND: wb_data = {{(data_width-1){1'b0}}, cond_true};
            default: wb_data = alu_result;
        endcase
    end

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .we      (reg_we),
        .waddr   (ir[11:8]),
        .raddr_a (ir[11:8]),
        .raddr_b (ir[3:0]),
        .wdata   (wb_data),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    alu u_alu (
        .a         (rdata_a),
        .b         (alu_b),
        .op        (alu_op),
        .carry_in  (c_flag),
        .result    (alu_result),
        .carry_out (alu_carry),
        .zero_eq   (alu_zero),
        .lower     (alu_lower)
    );

endmodule

`default_nettype wire

// File: hdl/control_and_decoder.sv
// cr16 control fsm, steps fetch/decode/execute and turns the instruction class into datapath strobes
`timescale 1ns/1ns
`default_nettype none

module control_and_decoder (
    input  logic                   clk,
    input  logic                   reset,
    input  cr16_pkg::instr_class_t instr_class,    // ir[15:12]
    input  cr16_pkg::alu_op_t      op_field,       // ir[7:4]
    output logic                   ir_load,
    output logic                   pc_inc,
    output logic                   reg_we,
    output logic                   flags_we,
    output logic                   mdr_load,
    output logic                   use_imm,
    output logic                   addr_sel,
    output logic [1:0]             wb_sel,
    output cr16_pkg::alu_op_t      alu_op,
    output logic                   mem_we,
    output logic                   halted
);
    import cr16_pkg::*;

    cpu_state_t state;
    cpu_state_t next_state;
    cpu_state_t prev_state;
    logic       op_writes_reg;      // register-form op has a destination
    logic       op_sets_flags;      // register-form op updates c or z/l

    // state register, prev_state trails by one cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state      <= S_FETCH;
            prev_state <= S_FETCH;
        end else begin
            prev_state <= state;
            state      <= next_state;
        end
    end

    // which register-form ops write rdest and which touch flags
    always_comb begin
        op_writes_reg = 1'b1;
        op_sets_flags = 1'b0;
        case (op_field)
            NOP: op_writes_reg = 1'b0;
            CMP: begin
                op_writes_reg = 1'b0;   // compare only sets z and l
                op_sets_flags = 1'b1;
            end
            ADD, ADDC, SUB, SUBC: op_sets_flags = 1'b1;    // carry / borrow
            default: op_sets_flags = 1'b0;  // addu, logic, shifts, mov
        endcase
    end

    // next state
    always_comb begin
        next_state = S_FETCH;
        case (state)
            S_FETCH:  next_state = S_DECODE;
            S_DECODE: begin
                case (instr_class)
                    CLS_RTYPE, CLS_ADDI,
                    CLS_MOVI, CLS_SCOND: next_state = S_EXEC;
                    CLS_LOAD:            next_state = S_LOAD_ADDR;
                    CLS_STOR:            next_state = S_STORE;
                    CLS_HALT:            next_state = S_HALT;
                    default:             next_state = S_FETCH;    // unused class acts as no-op
                endcase
            end
            S_EXEC:      next_state = S_FETCH;
            S_STORE:     next_state = S_FETCH;
            S_LOAD_ADDR: next_state = S_LOAD_WB;
            S_LOAD_WB:   next_state = S_FETCH;
            S_HALT:      next_state = S_HALT;     // parked until reset
            default:     next_state = S_FETCH;
        endcase
    end

    // control outputs, everything idle unless the state asks for it
    always_comb begin
        ir_load  = 1'b0;
        pc_inc   = 1'b0;
        reg_we   = 1'b0;
        flags_we = 1'b0;
        mdr_load = 1'b0;
        use_imm  = 1'b0;
        addr_sel = ADDR_PC;
        wb_sel   = WB_ALU;
        alu_op   = NOP;
        mem_we   = 1'b0;
        halted   = 1'b0;
        case (state)
            S_FETCH: begin
                ir_load = 1'b1;         // ir <= mem[pc]
                pc_inc  = 1'b1;
            end
            S_EXEC: begin
                case (instr_class)
                    CLS_RTYPE: begin
                        alu_op   = op_field;
                        reg_we   = op_writes_reg;
                        flags_we = op_sets_flags;
                    end
                    CLS_ADDI: begin
                        alu_op   = ADD;     // add with sign-extended immediate
                        use_imm  = 1'b1;
                        reg_we   = 1'b1;
                        flags_we = 1'b1;
                    end
                    CLS_MOVI: begin
                        alu_op  = MOV;
                        use_imm = 1'b1;
                        reg_we  = 1'b1;
                    end
                    CLS_SCOND: begin
                        wb_sel = WB_COND;   // 1 or 0 from z / l
                        reg_we = 1'b1;
                    end
                    default: reg_we = 1'b0;
                endcase
            end
            S_STORE: begin
                addr_sel = ADDR_REG;                    // address from rsrc
                mem_we   = (prev_state == S_DECODE);    // single strobe on entry
            end
            S_LOAD_ADDR: begin
                addr_sel = ADDR_REG;
                mdr_load = 1'b1;
            end
            S_LOAD_WB: begin
                wb_sel = WB_MDR;
                reg_we = 1'b1;
            end
            S_HALT:  halted = 1'b1;
            default: halted = 1'b0;     // decode has no strobes
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/regfile.sv
// cr16 register file, sixteen words with two asynchronous read ports and one clocked write port
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            we,
    input  logic [3:0]                      waddr,
    input  logic [3:0]                      raddr_a,
    input  logic [3:0]                      raddr_b,
    input  logic [cr16_pkg::data_width-1:0] wdata,
    output logic [cr16_pkg::data_width-1:0] rdata_a,
    output logic [cr16_pkg::data_width-1:0] rdata_b
);
    import cr16_pkg::*;

    logic [data_width-1:0] regs [16];

    // all registers start at zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;   // lands at the closing edge of exec / load_wb
        end
    end

    // reads see the old value during a write cycle
    assign rdata_a = regs[raddr_a];     // rdest
    assign rdata_b = regs[raddr_b];     // rsrc

endmodule

`default_nettype wire

// File: hdl/alu.sv
// combinational cr16 alu, gives the result plus carry/borrow and compare outputs for each opcode
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic [cr16_pkg::data_width-1:0] a,          // rdest value
    input  logic [cr16_pkg::data_width-1:0] b,          // rsrc value or immediate
    input  cr16_pkg::alu_op_t               op,
    input  logic                            carry_in,   // c flag
    output logic [cr16_pkg::data_width-1:0] result,
    output logic                            carry_out,  // carry for add, borrow for sub
    output logic                            zero_eq,    // a == b
    output logic                            lower       // a < b unsigned
);
    import cr16_pkg::*;

    logic [data_width:0]   sum;         // msb is carry out
    logic [data_width:0]   diff;        // msb is borrow out
    logic                  use_c;       // only the c variants fold in the flag
    logic [4:0]            shamt;       // signed shift amount from b
    logic [4:0]            shmag;       // its magnitude
    logic [data_width-1:0] lsh_res;
    logic [data_width-1:0] ashu_res;

    assign use_c = (op == ADDC) || (op == SUBC);

    assign sum  = {1'b0, a} + {1'b0, b} + {{data_width{1'b0}}, use_c & carry_in};
    assign diff = {1'b0, a} - {1'b0, b} - {{data_width{1'b0}}, use_c & carry_in};

    // shift count is the low five bits of b, two's complement
    assign shamt = b[4:0];
    assign shmag = shamt[4] ? (~shamt + 5'd1) : shamt;    // -16 maps to 16

    assign lsh_res  = shamt[4] ? (a >> shmag) : (a << shmag);            // zero fill right
    assign ashu_res = shamt[4] ? $unsigned($signed(a) >>> shmag) : (a << shmag);  // sign fill

    assign zero_eq = (a == b);
    assign lower   = (a < b);

    always_comb begin
        result    = a;      // nop passes a through, it is never written back
        carry_out = 1'b0;
        case (op)
            AND:  result = a & b;
            OR:   result = a | b;
            XOR:  result = a ^ b;
            NOT:  result = ~b;
            MOV:  result = b;
            LSH:  result = lsh_res;
            ASHU: result = ashu_res;
            ADD, ADDU, ADDC: begin
                result    = sum[data_width-1:0];
                carry_out = sum[data_width];
            end
            SUB, SUBC, CMP: begin
                result    = diff[data_width-1:0];   // cmp result is dropped
                carry_out = diff[data_width];
            end
            default: result = a;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/cr16_pkg.sv
// shared widths, instruction encodings and fsm states for the cr16 core, imported by all rtl
`default_nettype none

package cr16_pkg;

    localparam int data_width = 16;     // registers, memory words and addresses

    // instruction word layout
    //   [15:12] class   [11:8] rdest   [7:4] alu op or condition   [3:0] rsrc
    //   addi / movi use [7:0] as a signed 8-bit immediate instead of op and rsrc
    typedef enum logic [3:0] {
        CLS_RTYPE = 4'd0,   // register-form alu op
        CLS_ADDI  = 4'd1,
        CLS_MOVI  = 4'd2,
        CLS_LOAD  = 4'd3,   // rdest <= mem[rsrc]
        CLS_STOR  = 4'd4,   // mem[rsrc] <= rdest
        CLS_SCOND = 4'd5,   // rdest <= cond ? 1 : 0
        CLS_HALT  = 4'd6
    } instr_class_t;

    // alu opcodes, cr16a encodings
    typedef enum logic [3:0] {
        NOP  = 4'b0000, AND  = 4'b0001, OR   = 4'b0010, XOR  = 4'b0011,
        LSH  = 4'b0100, ADD  = 4'b0101, ADDU = 4'b0110, ADDC = 4'b0111,
        NOT  = 4'b1000, SUB  = 4'b1001, SUBC = 4'b1010, CMP  = 4'b1011,
        ASHU = 4'b1100, MOV  = 4'b1101
    } alu_op_t;

    typedef enum logic [3:0] {
        COND_EQ = 4'd0,     // z set
        COND_NE = 4'd1,     // z clear
        COND_LO = 4'd2,     // l set
        COND_HS = 4'd3      // l clear
    } cond_t;

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXEC, S_STORE, S_LOAD_ADDR, S_LOAD_WB, S_HALT
    } cpu_state_t;

    localparam logic [1:0] WB_ALU   = 2'd0;     // write-back source select
    localparam logic [1:0] WB_MDR   = 2'd1;
    localparam logic [1:0] WB_COND  = 2'd2;
    localparam logic       ADDR_PC  = 1'b0;     // memory address select
    localparam logic       ADDR_REG = 1'b1;

endpackage

`default_nettype wire
